//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_lsu_tb
FILELIST  ?= mem_lsu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- mem_lsu.f
+incdir+src
src/lsu_pkg.sv
src/tlb.sv
src/store_buffer.sv
src/load_store_controller.sv
src/mem_lsu.sv
tests/mem_lsu_properties.sv
tests/mem_lsu_tb.sv

//--- src/load_store_controller.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module load_store_controller (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          load_we,
    input  logic          store_we,
    input  logic [31:0]   address,
    input  logic [31:0]   store_data,
    input  logic          tlb_hit,
    input  lsu_pkg::ppn_t lookup_ppn,
    input  logic          fwd_hit,
    input  logic [31:0]   fwd_data,
    input  logic          full,
    input  logic          mem_rvalid,
    input  logic [31:0]   mem_rdata,
    output logic          busy,
    output logic          store_done,
    output logic          load_valid,
    output logic [31:0]   load_data,
    output logic          tlb_miss,
    output lsu_pkg::vpn_t miss_vpn,
    output lsu_pkg::vpn_t lookup_vpn,
    output logic          push,
    output logic [31:0]   push_address,
    output logic [31:0]   push_data,
    output logic [31:0]   fwd_address,
    output logic          mem_read,
    output logic [31:0]   mem_read_address,
    output logic          mem_hold
);

    localparam int PB = `LSU_PAGE_BITS;

    lsu_pkg::lsu_state_t state;
    lsu_pkg::mem_op_t    op_q;
    logic [31:0]         addr_q;
    logic [31:0]         data_q;
    logic [31:0]         paddr;
    logic [31:0]         paddr_q;
    logic                accept;
    logic                in_lookup;
    logic                is_store;

    assign busy      = (state != lsu_pkg::LSU_IDLE);
    assign accept    = (load_we | store_we) & ~busy;
    assign in_lookup = (state == lsu_pkg::LSU_LOOKUP);
    assign is_store  = (op_q == lsu_pkg::OP_STORE);

    // physical address is ppn joined with the page offset
    assign lookup_vpn  = addr_q[31:PB];
    assign paddr       = {lookup_ppn, addr_q[PB-1:0]};
    assign fwd_address = paddr;

    assign push = (in_lookup & is_store & tlb_hit & ~full) |
                  ((state == lsu_pkg::LSU_STORE_WAIT) & ~full);
    assign push_address = (state == lsu_pkg::LSU_STORE_WAIT) ? paddr_q : paddr;
    assign push_data    = data_q;

    // keeps the drain off the bus from a load's lookup until its reply
    assign mem_hold = (state == lsu_pkg::LSU_MEM_WAIT) | (in_lookup & ~is_store);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= lsu_pkg::LSU_IDLE;
            op_q       <= lsu_pkg::OP_LOAD;
            store_done <= 1'b0;
            load_valid <= 1'b0;
            tlb_miss   <= 1'b0;
            mem_read   <= 1'b0;
        end else begin
            store_done <= 1'b0;
            load_valid <= 1'b0;
            tlb_miss   <= 1'b0;
            mem_read   <= 1'b0;
            case (state)
                lsu_pkg::LSU_IDLE: begin
                    if (accept) begin
                        op_q  <= store_we ? lsu_pkg::OP_STORE : lsu_pkg::OP_LOAD;
                        state <= lsu_pkg::LSU_LOOKUP;
                    end
                end
                lsu_pkg::LSU_LOOKUP: begin
                    if (!tlb_hit) begin
                        tlb_miss <= 1'b1;
                        state    <= lsu_pkg::LSU_IDLE;
                    end else if (is_store) begin
                        if (full) begin
                            state <= lsu_pkg::LSU_STORE_WAIT;
                        end else begin
                            store_done <= 1'b1;
                            state      <= lsu_pkg::LSU_IDLE;
                        end
                    end else if (fwd_hit) begin
                        load_valid <= 1'b1;
                        state      <= lsu_pkg::LSU_IDLE;
                    end else begin
                        mem_read <= 1'b1;
                        state    <= lsu_pkg::LSU_MEM_WAIT;
                    end
                end
                lsu_pkg::LSU_STORE_WAIT: begin
                    if (!full) begin
                        store_done <= 1'b1;
                        state      <= lsu_pkg::LSU_IDLE;
                    end
                end
                lsu_pkg::LSU_MEM_WAIT: begin
                    if (mem_rvalid) begin
                        load_valid <= 1'b1;
                        state      <= lsu_pkg::LSU_IDLE;
                    end
                end
                default: state <= lsu_pkg::LSU_IDLE;
            endcase
        end
    end

    // request and result payload
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= address;
            data_q <= store_data;
        end
        if (in_lookup) begin
            paddr_q          <= paddr;
            miss_vpn         <= lookup_vpn;
            mem_read_address <= paddr;
        end
        if (in_lookup && !is_store && fwd_hit)
            load_data <= fwd_data;
        else if (state == lsu_pkg::LSU_MEM_WAIT && mem_rvalid)
            load_data <= mem_rdata;
    end

endmodule

//--- src/lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// translation buffer entries
`define LSU_TLB_ENTRIES 4

// store buffer depth, power of two
`define LSU_SB_DEPTH 4

// 4 KB pages
`define LSU_PAGE_BITS 12

`endif

//--- src/lsu_pkg.sv
`include "lsu_config.svh"

package lsu_pkg;

    // controller states
    typedef enum logic [1:0] {
        LSU_IDLE       = 2'd0,
        LSU_LOOKUP     = 2'd1,
        LSU_STORE_WAIT = 2'd2,
        LSU_MEM_WAIT   = 2'd3
    } lsu_state_t;

    // operation of the held request
    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mem_op_t;

    // page numbers, address width minus page offset
    typedef logic [31-`LSU_PAGE_BITS:0] vpn_t;
    typedef logic [31-`LSU_PAGE_BITS:0] ppn_t;

endpackage

//--- src/mem_lsu.sv
`timescale 1ns/1ps

module mem_lsu (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          load_we,
    input  logic          store_we,
    input  logic [31:0]   address,
    input  logic [31:0]   store_data,
    output logic          busy,
    output logic          store_done,
    output logic          load_valid,
    output logic [31:0]   load_data,
    output logic          tlb_miss,
    output lsu_pkg::vpn_t miss_vpn,
    input  logic          tlb_we,
    input  lsu_pkg::vpn_t tlb_vpn,
    input  lsu_pkg::ppn_t tlb_ppn,
    input  logic          mem_ready,
    output logic          mem_write_en,
    output logic [31:0]   mem_address,
    output logic [31:0]   mem_data,
    output logic          mem_read,
    output logic [31:0]   mem_read_address,
    input  logic          mem_rvalid,
    input  logic [31:0]   mem_rdata
);

    lsu_pkg::vpn_t lookup_vpn;
    lsu_pkg::ppn_t lookup_ppn;
    logic          tlb_hit;
    logic          push;
    logic [31:0]   push_address;
    logic [31:0]   push_data;
    logic [31:0]   fwd_address;
    logic          fwd_hit;
    logic [31:0]   fwd_data;
    logic          full;
    logic          empty;
    logic          mem_hold;

    load_store_controller u_load_store_controller (
        .clk(clk),
        .rst_n(rst_n),
        .load_we(load_we),
        .store_we(store_we),
        .address(address),
        .store_data(store_data),
        .tlb_hit(tlb_hit),
        .lookup_ppn(lookup_ppn),
        .fwd_hit(fwd_hit),
        .fwd_data(fwd_data),
        .full(full),
        .mem_rvalid(mem_rvalid),
        .mem_rdata(mem_rdata),
        .busy(busy),
        .store_done(store_done),
        .load_valid(load_valid),
        .load_data(load_data),
        .tlb_miss(tlb_miss),
        .miss_vpn(miss_vpn),
        .lookup_vpn(lookup_vpn),
        .push(push),
        .push_address(push_address),
        .push_data(push_data),
        .fwd_address(fwd_address),
        .mem_read(mem_read),
        .mem_read_address(mem_read_address),
        .mem_hold(mem_hold)
    );

    tlb u_tlb (
        .clk(clk),
        .rst_n(rst_n),
        .tlb_we(tlb_we),
        .tlb_vpn(tlb_vpn),
        .tlb_ppn(tlb_ppn),
        .lookup_vpn(lookup_vpn),
        .tlb_hit(tlb_hit),
        .lookup_ppn(lookup_ppn)
    );

    store_buffer u_store_buffer (
        .clk(clk),
        .rst_n(rst_n),
        .push(push),
        .push_address(push_address),
        .push_data(push_data),
        .fwd_address(fwd_address),
        .mem_ready(mem_ready),
        .mem_hold(mem_hold),
        .fwd_hit(fwd_hit),
        .fwd_data(fwd_data),
        .full(full),
        .empty(empty),
        .mem_write_en(mem_write_en),
        .mem_address(mem_address),
        .mem_data(mem_data)
    );

endmodule

//--- src/store_buffer.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module store_buffer #(
    parameter int DEPTH = `LSU_SB_DEPTH
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        push,
    input  logic [31:0] push_address,
    input  logic [31:0] push_data,
    input  logic [31:0] fwd_address,
    input  logic        mem_ready,
    input  logic        mem_hold,
    output logic        fwd_hit,
    output logic [31:0] fwd_data,
    output logic        full,
    output logic        empty,
    output logic        mem_write_en,
    output logic [31:0] mem_address,
    output logic [31:0] mem_data
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [31:0]      addr_mem [DEPTH];
    logic [31:0]      data_mem [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             drain;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // no drain while a load is using the memory port
    assign drain = mem_ready & ~empty & ~mem_hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            mem_write_en <= 1'b0;
        end else begin
            mem_write_en <= drain;
            if (push)
                tail <= next_ptr(tail);
            if (drain)
                head <= next_ptr(head);
            case ({push, drain})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[tail] <= push_address;
            data_mem[tail] <= push_data;
        end
        if (drain) begin
            mem_address <= addr_mem[head];
            mem_data    <= data_mem[head];
        end
    end

    // walk oldest to youngest, so the last match is the youngest store
    always_comb begin
        logic [CNT_W-1:0] slot;
        fwd_hit  = 1'b0;
        fwd_data = '0;
        for (int i = 0; i < DEPTH; i++) begin
            slot = {1'b0, head} + CNT_W'(i);
            if (slot >= CNT_W'(DEPTH))
                slot = slot - CNT_W'(DEPTH);
            if (CNT_W'(i) < count &&
                addr_mem[slot[PTR_W-1:0]][31:2] == fwd_address[31:2]) begin
                fwd_hit  = 1'b1;
                fwd_data = data_mem[slot[PTR_W-1:0]];
            end
        end
    end

endmodule

//--- src/tlb.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module tlb (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         tlb_we,
    input  lsu_pkg::vpn_t tlb_vpn,
    input  lsu_pkg::ppn_t tlb_ppn,
    input  lsu_pkg::vpn_t lookup_vpn,
    output logic         tlb_hit,
    output lsu_pkg::ppn_t lookup_ppn
);

    localparam int ENTRIES = `LSU_TLB_ENTRIES;
    localparam int IDX_W   = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

    logic                  valid [ENTRIES];
    lsu_pkg::vpn_t         vpn_mem [ENTRIES];
    lsu_pkg::ppn_t         ppn_mem [ENTRIES];
    logic [IDX_W-1:0]      rr_ptr;
    logic                  fill_match;
    logic [IDX_W-1:0]      fill_idx;
    logic [IDX_W-1:0]      wr_idx;

    // an existing mapping for the same page is reused
    always_comb begin
        fill_match = 1'b0;
        fill_idx   = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (valid[i] && vpn_mem[i] == tlb_vpn) begin
                fill_match = 1'b1;
                fill_idx   = IDX_W'(i);
            end
        end
    end

    assign wr_idx = fill_match ? fill_idx : rr_ptr;

    // valid bits and replacement pointer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_ptr <= '0;
            for (int i = 0; i < ENTRIES; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (tlb_we) begin
            valid[wr_idx] <= 1'b1;
            if (!fill_match) begin
                if (rr_ptr == IDX_W'(ENTRIES - 1))
                    rr_ptr <= '0;
                else
                    rr_ptr <= rr_ptr + 1'b1;
            end
        end
    end

    // mapping storage
    always_ff @(posedge clk) begin
        if (tlb_we) begin
            vpn_mem[wr_idx] <= tlb_vpn;
            ppn_mem[wr_idx] <= tlb_ppn;
        end
    end

    // parallel compare, at most one entry can match
    always_comb begin
        tlb_hit    = 1'b0;
        lookup_ppn = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (valid[i] && vpn_mem[i] == lookup_vpn) begin
                tlb_hit    = 1'b1;
                lookup_ppn = ppn_mem[i];
            end
        end
    end

endmodule

//--- tests/lsu_tests.txt
# columns: command, then hex fields
# F vpn ppn | S vaddr data | L vaddr expected | M vaddr vpn | P paddr data | R mode | D
# R mode is 0 for mem_ready low, 1 for high, 2 for random
R 1
F 00010 00a20
F 00011 00b31
F 00012 00c42
F 00013 00d53
S 00010004 11110001
S 00011ff8 22220002
S 00013010 33330003
D
M 00020000 00020
M 0abcd123 0abcd
# forwarding with the buffer held
R 0
S 00012100 44440004
S 00012100 55550005
L 00012100 55550005
P 00c42200 cafe0001
L 00012200 cafe0001
R 1
D
# fifth store stalls until memory is ready
R 0
S 00010100 a0000001
S 00011104 a0000002
S 00012108 a0000003
S 0001310c a0000004
S 00010110 a0000005
R 2
D
P 00d53020 0bad0001
L 00013020 0bad0001
L 00010100 a0000001
L 00011ff8 22220002
# fifth fill evicts page 00010
F 00030 00e64
M 00010008 00010
S 00030abc 66660006
S 00012000 77770007
L 00030abc 66660006
L 00013010 33330003
D

//--- tests/mem_lsu_properties.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module mem_lsu_properties (
    input logic clk,
    input logic rst_n,
    input logic load_we,
    input logic store_we,
    input logic busy,
    input logic store_done,
    input logic load_valid,
    input logic tlb_miss,
    input logic mem_read,
    input logic mem_rvalid,
    input logic mem_write_en,
    input logic push,
    input logic full,
    input logic empty
);

    logic read_pending;
    logic req_open;
    logic accepted;
    logic completed;
    int   sb_level;
    int   sb_used;

    assign accepted  = (load_we || store_we) && !busy;
    assign completed = store_done || load_valid || tlb_miss;

    // from the read pulse until the reply
    always_ff @(posedge clk) begin
        if (!rst_n)
            read_pending <= 1'b0;
        else if (mem_read)
            read_pending <= 1'b1;
        else if (mem_rvalid)
            read_pending <= 1'b0;
    end

    // from an accepted request until its completion pulse
    always_ff @(posedge clk) begin
        if (!rst_n)
            req_open <= 1'b0;
        else if (accepted)
            req_open <= 1'b1;
        else if (completed)
            req_open <= 1'b0;
    end

    // pushes not yet seen as a memory write
    always_ff @(posedge clk) begin
        if (!rst_n)
            sb_level <= 0;
        else
            sb_level <= sb_level + int'(push) - int'(mem_write_en);
    end

    // a write pulse means its entry left at the edge before
    assign sb_used = sb_level - int'(mem_write_en);

    single_request: assert property (@(posedge clk) disable iff (!rst_n)
        !(load_we && store_we))
        else $error("load and store requested in the same cycle");

    no_write_during_read: assert property (@(posedge clk) disable iff (!rst_n)
        mem_write_en |-> !(mem_read || read_pending))
        else $error("memory write while a read is outstanding");

    one_completion: assert property (@(posedge clk) disable iff (!rst_n)
        completed |-> req_open && $onehot({store_done, load_valid, tlb_miss}))
        else $error("completion pulse without a single open request");

    no_lost_request: assert property (@(posedge clk) disable iff (!rst_n)
        accepted |-> !req_open || completed)
        else $error("new request accepted before the last one completed");

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !full && sb_used < `LSU_SB_DEPTH)
        else $error("store buffer pushed while full");

    level_flags: assert property (@(posedge clk) disable iff (!rst_n)
        full == (sb_used == `LSU_SB_DEPTH) && empty == (sb_used == 0))
        else $error("store buffer full or empty flag disagrees with its level");

endmodule

bind mem_lsu mem_lsu_properties mem_lsu_properties_inst (
    .clk(clk),
    .rst_n(rst_n),
    .load_we(load_we),
    .store_we(store_we),
    .busy(busy),
    .store_done(store_done),
    .load_valid(load_valid),
    .tlb_miss(tlb_miss),
    .mem_read(mem_read),
    .mem_rvalid(mem_rvalid),
    .mem_write_en(mem_write_en),
    .push(push),
    .full(full),
    .empty(empty)
);

//--- tests/mem_lsu_tb.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module mem_lsu_tb;

    localparam int CLK_PERIOD      = 100;
    localparam int CYCLES_PER_LINE = 300;

    logic          clk;
    logic          rst_n;
    logic          load_we;
    logic          store_we;
    logic [31:0]   address;
    logic [31:0]   store_data;
    logic          busy;
    logic          store_done;
    logic          load_valid;
    logic [31:0]   load_data;
    logic          tlb_miss;
    lsu_pkg::vpn_t miss_vpn;
    logic          tlb_we;
    lsu_pkg::vpn_t tlb_vpn;
    lsu_pkg::ppn_t tlb_ppn;
    logic          mem_ready;
    logic          mem_write_en;
    logic [31:0]   mem_address;
    logic [31:0]   mem_data;
    logic          mem_read;
    logic [31:0]   mem_read_address;
    logic          mem_rvalid;
    logic [31:0]   mem_rdata;

    string         lines [$];
    int            line_total;
    int            ready_mode;
    int            read_count;
    logic [31:0]   mem_model [logic [31:0]];
    lsu_pkg::ppn_t page_map [lsu_pkg::vpn_t];
    // physical address in the upper half, data in the lower
    logic [63:0]   exp_writes [$];

    mem_lsu mem_lsu_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            stop_run($sformatf("FAILED %s: got %h, expected %h", name, actual, expected));
    endtask

    function automatic logic [31:0] translate(input logic [31:0] vaddr);
        lsu_pkg::vpn_t vpn;
        vpn = vaddr[31:`LSU_PAGE_BITS];
        return {page_map[vpn], vaddr[`LSU_PAGE_BITS-1:0]};
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem_model.exists(addr))
            return mem_model[addr];
        return {addr[15:0], addr[31:16]} ^ 32'h5a3c_c3a5;
    endfunction

    task automatic issue_request(input logic is_store, input logic [31:0] addr,
                                 input logic [31:0] data);
        int n;
        n = 0;
        @(negedge clk);
        while (busy) begin
            if (n == 200)
                stop_run("DUT stayed busy and took no new request");
            n++;
            @(negedge clk);
        end
        @(posedge clk);
        store_we   <= is_store;
        load_we    <= ~is_store;
        address    <= addr;
        store_data <= data;
        @(posedge clk);
        store_we <= 1'b0;
        load_we  <= 1'b0;
    endtask

    // pulses come back as {tlb_miss, load_valid, store_done}
    task automatic await_completion(input int limit, output logic [2:0] pulses);
        int n;
        pulses = 3'b000;
        n = 0;
        while (pulses == 3'b000 && n < limit) begin
            @(negedge clk);
            pulses = {tlb_miss, load_valid, store_done};
            n++;
        end
    endtask

    always @(posedge clk) begin
        if (ready_mode == 2)
            mem_ready <= 1'($urandom_range(1, 0));
        else
            mem_ready <= (ready_mode == 1);
    end

    // read reply after one to four cycles
    initial begin
        int lat;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        forever begin
            @(negedge clk);
            if (mem_read) begin
                read_count++;
                lat = int'($urandom_range(4, 1));
                repeat (lat) @(posedge clk);
                mem_rvalid <= 1'b1;
                mem_rdata  <= read_word(mem_read_address);
                @(posedge clk);
                mem_rvalid <= 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && mem_write_en) begin
            if (exp_writes.size() == 0) begin
                stop_run("memory write arrived with no store outstanding");
            end else begin
                check_value("mem_address", mem_address, exp_writes[0][63:32]);
                check_value("mem_data", mem_data, exp_writes[0][31:0]);
                mem_model[mem_address] = mem_data;
                void'(exp_writes.pop_front());
            end
        end
    end

    initial begin
        wait (line_total > 0);
        repeat (line_total * CYCLES_PER_LINE) @(posedge clk);
        stop_run($sformatf("watchdog expired after %0d cycles",
                           line_total * CYCLES_PER_LINE));
    end

    initial begin
        int          fd;
        int          n;
        int          reads_before;
        string       line;
        logic [7:0]  cmd;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] paddr;
        logic [2:0]  pulses;
        logic        fwd_expected;
        logic        stall_pending;

        void'($urandom(61636));
        rst_n         = 1'b0;
        load_we       = 1'b0;
        store_we      = 1'b0;
        address       = '0;
        store_data    = '0;
        tlb_we        = 1'b0;
        tlb_vpn       = '0;
        tlb_ppn       = '0;
        mem_ready     = 1'b0;
        ready_mode    = 0;
        read_count    = 0;
        stall_pending = 1'b0;

        fd = $fopen("tests/lsu_tests.txt", "r");
        if (fd == 0)
            stop_run("cannot open tests/lsu_tests.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#")
                lines.push_back(line);
        end
        $fclose(fd);
        if (lines.size() == 0)
            stop_run("test file holds no commands");
        line_total = lines.size();

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        foreach (lines[i]) begin
            cmd = 8'h00;
            f1  = '0;
            f2  = '0;
            n   = $sscanf(lines[i], "%c %h %h", cmd, f1, f2);
            case (cmd)
                "F": begin
                    @(posedge clk);
                    tlb_we  <= 1'b1;
                    tlb_vpn <= lsu_pkg::vpn_t'(f1);
                    tlb_ppn <= lsu_pkg::ppn_t'(f2);
                    @(posedge clk);
                    tlb_we <= 1'b0;
                    page_map[lsu_pkg::vpn_t'(f1)] = lsu_pkg::ppn_t'(f2);
                end
                "S": begin
                    exp_writes.push_back({translate(f1), f2});
                    issue_request(1'b1, f1, f2);
                    await_completion(16, pulses);
                    // full buffer with memory held off
                    if (ready_mode == 0 && exp_writes.size() > `LSU_SB_DEPTH) begin
                        check_value("completion", 32'(pulses), 32'h0);
                        check_value("busy", 32'(busy), 32'h1);
                        stall_pending = 1'b1;
                    end else begin
                        check_value("completion", 32'(pulses), 32'h1);
                    end
                end
                "L": begin
                    paddr        = translate(f1);
                    fwd_expected = 1'b0;
                    foreach (exp_writes[j]) begin
                        if (exp_writes[j][63:34] == paddr[31:2])
                            fwd_expected = 1'b1;
                    end
                    reads_before = read_count;
                    issue_request(1'b0, f1, '0);
                    await_completion(16, pulses);
                    check_value("completion", 32'(pulses), 32'h2);
                    check_value("load_data", load_data, f2);
                    if (ready_mode == 0)
                        check_value("mem_read count", 32'(read_count - reads_before),
                                    fwd_expected ? 32'h0 : 32'h1);
                end
                "M": begin
                    issue_request(1'b0, f1, '0);
                    await_completion(16, pulses);
                    check_value("completion", 32'(pulses), 32'h4);
                    check_value("miss_vpn", 32'(miss_vpn), f2);
                end
                "P": mem_model[f1] = f2;
                "R": begin
                    ready_mode = int'(f1);
                    if (stall_pending) begin
                        await_completion(200, pulses);
                        check_value("completion", 32'(pulses), 32'h1);
                        stall_pending = 1'b0;
                    end
                end
                "D": begin
                    n = 0;
                    while (exp_writes.size() != 0) begin
                        if (n == 1000)
                            stop_run("buffered stores never reached memory");
                        n++;
                        @(posedge clk);
                    end
                end
                default: stop_run($sformatf("unknown command in test line: %s", lines[i]));
            endcase
        end

        if (stall_pending || exp_writes.size() != 0) begin
            stop_run("stores still undelivered at the end of the test");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule
